// File: build.f
hdl/corr_pkg.sv
hdl/quad_bus_if.sv
hdl/sample_quadrature.sv
hdl/baseline_correlator.sv
hdl/visibility_readout.sv
hdl/correlator_top.sv
tests/tb_clock.sv
tests/correlator_tb.sv

// File: hdl/baseline_correlator.sv
`timescale 1ns/100ps

module baseline_correlator #(
   parameter int ANT_A = 0, // antenna whose in-phase bit is the reference.
   parameter int ANT_B = 1  // antenna compared against it.
) (
   input  logic                 clk,
   input  logic                 rst,
   quad_bus_if.dst              q,
   output corr_pkg::vis_count_t vis_re,
   output corr_pkg::vis_count_t vis_im,
   output logic                 done
);

   logic                 agree_re; // in-phase bits of both antennas match.
   logic                 agree_im; // in-phase of a matches quadrature of b.
   logic                 block_end; // this strobe carries the last sample.
   corr_pkg::vis_count_t acc_re;   // running real agreement count.
   corr_pkg::vis_count_t acc_im;   // running imaginary agreement count.
   corr_pkg::vis_count_t sum_re;   // real count including the current sample.
   corr_pkg::vis_count_t sum_im;   // imaginary count including the current sample.

   // ==========================================================
   // 1-bit multiply by xnor
   // ==========================================================

   // for 1-bit signals a product is +1 on agreement, so counting
   // agreements is all the correlation there is to do.
   assign agree_re  = q.re[ANT_A] == q.re[ANT_B];
   assign agree_im  = q.re[ANT_A] == q.im[ANT_B];
   assign block_end = q.strobe && q.last;

   assign sum_re = acc_re + corr_pkg::vis_count_t'(agree_re);
   assign sum_im = acc_im + corr_pkg::vis_count_t'(agree_im);

   // ==========================================================
   // accumulate and dump
   // ==========================================================

   always_ff @(posedge clk) begin
      if (rst) begin
         acc_re <= '0;
         acc_im <= '0;
      end else if (block_end) begin
         acc_re <= '0; // the next block starts from nothing.
         acc_im <= '0;
      end else if (q.strobe) begin
         acc_re <= sum_re; // one more sample folded in.
         acc_im <= sum_im;
      end
   end

   // the totals hold until the next block finishes.
   always_ff @(posedge clk) begin
      if (block_end) begin
         vis_re <= sum_re; // includes the sixteenth sample.
         vis_im <= sum_im;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         done <= 1'b0;
      end else begin
         done <= block_end; // one-cycle pulse alongside fresh totals.
      end
   end

   // the front end must close every block after BLOCK_LEN strobes.
   acc_bound_a : assert property (
      @(posedge clk) disable iff (rst)
         (acc_re <= corr_pkg::BLOCK_LEN) && (acc_im <= corr_pkg::BLOCK_LEN)
   );

endmodule

// File: hdl/corr_pkg.sv
package corr_pkg;

   // ==========================================================
   // array geometry
   // ==========================================================

   localparam int ANT_COUNT        = 4;  // one 1-bit sampler per antenna.
   localparam int BASELINE_COUNT   = 6;  // every unordered antenna pair.
   localparam int TICKS_PER_SAMPLE = 4;  // the sampler runs at 4x oversampling.
   localparam int BLOCK_LEN        = 16; // samples summed into one visibility.

   // ==========================================================
   // vector types
   // ==========================================================

   typedef logic [ANT_COUNT-1:0]                  sample_t;      // bit n belongs to antenna n.
   typedef logic [$clog2(BLOCK_LEN+1)-1:0]        vis_count_t;   // holds 0 up to BLOCK_LEN.
   typedef logic [$clog2(BASELINE_COUNT)-1:0]     baseline_t;    // index into the pair tables.
   typedef logic [$clog2(TICKS_PER_SAMPLE)-1:0]   tick_t;        // phase within one period.
   typedef logic [$clog2(BLOCK_LEN)-1:0]          block_count_t; // sample position in a block.

   // ==========================================================
   // baseline tables
   // ==========================================================

   // entry i names the two antennas that baseline i correlates.
   localparam int BASE_ANT_A [BASELINE_COUNT] = '{0, 0, 0, 1, 1, 2};
   localparam int BASE_ANT_B [BASELINE_COUNT] = '{1, 2, 3, 2, 3, 3};

   // readout sequencer states.
   typedef enum logic {
      RD_IDLE, // waiting for the correlators to finish a block.
      RD_SEND  // streaming one baseline per cycle.
   } readout_state_t;

endpackage

// File: hdl/correlator_top.sv
`timescale 1ns/100ps

module correlator_top (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 en,
   input  corr_pkg::sample_t    d,
   output logic                 vis_valid,
   output corr_pkg::baseline_t  vis_baseline,
   output corr_pkg::vis_count_t vis_re,
   output corr_pkg::vis_count_t vis_im
);

   logic [corr_pkg::BASELINE_COUNT-1:0] cell_done; // per-baseline block completion.
   corr_pkg::vis_count_t cell_re [corr_pkg::BASELINE_COUNT]; // per-baseline real totals.
   corr_pkg::vis_count_t cell_im [corr_pkg::BASELINE_COUNT]; // per-baseline imag totals.

   quad_bus_if qbus (); // sample bus shared by every correlator.

   // ==========================================================
   // front end
   // ==========================================================

   sample_quadrature u_feed (
      .clk (clk),
      .rst (rst),
      .en  (en),
      .d   (d),
      .q   (qbus.src)
   );

   // ==========================================================
   // one correlator per antenna pair
   // ==========================================================

   for (genvar i = 0; i < corr_pkg::BASELINE_COUNT; i++) begin : g_base
      baseline_correlator #(
         .ANT_A (corr_pkg::BASE_ANT_A[i]),
         .ANT_B (corr_pkg::BASE_ANT_B[i])
      ) u_corr (
         .clk    (clk),
         .rst    (rst),
         .q      (qbus.dst),
         .vis_re (cell_re[i]),
         .vis_im (cell_im[i]),
         .done   (cell_done[i])
      );
   end

   // serialises the six results onto the output port.
   visibility_readout u_readout (
      .clk          (clk),
      .rst          (rst),
      .done         (cell_done),
      .vis_re_in    (cell_re),
      .vis_im_in    (cell_im),
      .vis_valid    (vis_valid),
      .vis_baseline (vis_baseline),
      .vis_re       (vis_re),
      .vis_im       (vis_im)
   );

endmodule

// File: hdl/quad_bus_if.sv
`timescale 1ns/100ps

// shared sample bus from the quadrature front end to every correlator.
interface quad_bus_if;

   corr_pkg::sample_t re;     // in-phase word of the current sample.
   corr_pkg::sample_t im;     // quadrature word, the previous in-phase capture.
   logic              strobe; // one-cycle pulse when re and im change.
   logic              last;   // set with strobe on the final sample of a block.

   // the front end owns every signal on the bus.
   modport src (
      output re,
      output im,
      output strobe,
      output last
   );

   // each correlator only listens.
   modport dst (
      input  re,
      input  im,
      input  strobe,
      input  last
   );

endinterface

// File: hdl/sample_quadrature.sv
`timescale 1ns/100ps

module sample_quadrature (
   input  logic              clk,
   input  logic              rst,
   input  logic              en,
   input  corr_pkg::sample_t d,
   quad_bus_if.src           q
);

   corr_pkg::tick_t        phase;      // position inside the current sample period.
   corr_pkg::block_count_t sample_cnt; // strobes issued so far in this block.
   logic                   capture;    // high on the edge that takes a new word.
   logic                   phase_wrap; // high on the last tick of a period.
   logic                   block_end;  // next capture closes the block.

   // ==========================================================
   // sample period timing
   // ==========================================================

   assign capture    = en && (phase == '0); // words are only taken at phase 0.
   assign phase_wrap = phase == corr_pkg::tick_t'(corr_pkg::TICKS_PER_SAMPLE - 1);
   assign block_end  = sample_cnt == corr_pkg::block_count_t'(corr_pkg::BLOCK_LEN - 1);

   // once a period starts it runs to the end, even if en drops midway.
   always_ff @(posedge clk) begin
      if (rst) begin
         phase <= '0;
      end else if (en || phase != '0) begin
         phase <= phase_wrap ? '0 : phase + corr_pkg::tick_t'(1);
      end
   end

   // ==========================================================
   // capture and fake hilbert transform
   // ==========================================================

   // at 4x oversampling one sample period is roughly a quarter cycle of the
   // signal, so the word captured one period ago approximates the
   // 90 degree shifted component.
   always_ff @(posedge clk) begin
      if (rst) begin
         q.re <= '0; // no history after reset.
         q.im <= '0; // the first quadrature word is therefore zero.
      end else if (capture) begin
         q.re <= d;    // new in-phase word.
         q.im <= q.re; // previous in-phase word becomes the quadrature word.
      end
   end

   // ==========================================================
   // strobe and block framing
   // ==========================================================

   always_ff @(posedge clk) begin
      if (rst) begin
         q.strobe <= 1'b0;
         q.last   <= 1'b0;
      end else begin
         q.strobe <= capture;              // pulses in the cycle after a capture.
         q.last   <= capture && block_end; // flags the sixteenth capture of a block.
      end
   end

   // the previous strobe has always been counted by the next capture edge,
   // because captures are at least one sample period apart.
   always_ff @(posedge clk) begin
      if (rst) begin
         sample_cnt <= '0;
      end else if (q.strobe) begin
         sample_cnt <= sample_cnt + corr_pkg::block_count_t'(1); // wraps after a block.
      end
   end

   // a capture needs a full sample period, so strobes are never back to back.
   strobe_spacing_a : assert property (
      @(posedge clk) disable iff (rst) q.strobe |=> !q.strobe
   );

endmodule

// File: hdl/visibility_readout.sv
`timescale 1ns/100ps

module visibility_readout (
   input  logic                               clk,
   input  logic                               rst,
   input  logic [corr_pkg::BASELINE_COUNT-1:0] done,
   input  corr_pkg::vis_count_t               vis_re_in [corr_pkg::BASELINE_COUNT],
   input  corr_pkg::vis_count_t               vis_im_in [corr_pkg::BASELINE_COUNT],
   output logic                               vis_valid,
   output corr_pkg::baseline_t                vis_baseline,
   output corr_pkg::vis_count_t               vis_re,
   output corr_pkg::vis_count_t               vis_im
);

   corr_pkg::readout_state_t state;    // idle or streaming.
   corr_pkg::baseline_t      idx;      // baseline being presented.
   logic                     idx_last; // final baseline of the burst.
   corr_pkg::vis_count_t     lat_re [corr_pkg::BASELINE_COUNT]; // snapshot of real totals.
   corr_pkg::vis_count_t     lat_im [corr_pkg::BASELINE_COUNT]; // snapshot of imag totals.

   assign idx_last = idx == corr_pkg::baseline_t'(corr_pkg::BASELINE_COUNT - 1);

   // ==========================================================
   // snapshot of the correlator totals
   // ==========================================================

   // every correlator finishes on the same strobe, so bit 0 speaks for all.
   always_ff @(posedge clk) begin
      if (done[0]) begin
         lat_re <= vis_re_in; // the correlators may move on once this is taken.
         lat_im <= vis_im_in;
      end
   end

   // ==========================================================
   // readout sequencer
   // ==========================================================

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= corr_pkg::RD_IDLE;
         idx   <= '0;
      end else begin
         case (state)
            corr_pkg::RD_IDLE: begin
               if (done[0]) begin
                  state <= corr_pkg::RD_SEND;
               end
            end
            corr_pkg::RD_SEND: begin
               if (idx_last) begin
                  idx   <= '0; // every burst starts at baseline 0.
                  state <= corr_pkg::RD_IDLE;
               end else begin
                  idx <= idx + corr_pkg::baseline_t'(1); // one baseline per cycle.
               end
            end
            default: begin
               state <= corr_pkg::RD_IDLE;
            end
         endcase
      end
   end

   assign vis_valid    = state == corr_pkg::RD_SEND;
   assign vis_baseline = idx;
   assign vis_re       = lat_re[idx]; // idx never passes the last baseline.
   assign vis_im       = lat_im[idx];

   // the correlators share one strobe, so their done pulses must coincide.
   done_aligned_a : assert property (
      @(posedge clk) disable iff (rst) (done == '0) || (done == '1)
   );

   // a block is far longer than a burst, so no totals are ever dropped.
   no_overrun_a : assert property (
      @(posedge clk) disable iff (rst) done[0] |-> state == corr_pkg::RD_IDLE
   );

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the correlator testbench with Verilator and runs it.
# Exits 0 only when the run prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   -f build.f \
   --top-module correlator_tb \
   -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/Vcorrelator_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
   exit 0
else
   echo "pass message not found in simulation output"
   exit 1
fi

// File: tests/correlator_tb.sv
`timescale 1ns/100ps

module correlator_tb;

   // tests need about 540 cycles, so this leaves roughly a factor of two.
   localparam int CYCLE_LIMIT =
      2 * (116 + 6 * corr_pkg::BLOCK_LEN * corr_pkg::TICKS_PER_SAMPLE);

   logic                 clk;
   logic                 rst;
   logic                 en;           // sample period enable.
   corr_pkg::sample_t    d;            // one bit per antenna.
   logic                 vis_valid;
   corr_pkg::baseline_t  vis_baseline;
   corr_pkg::vis_count_t vis_re;
   corr_pkg::vis_count_t vis_im;

   int checks = 0;  // compares made so far.
   int errors = 0;  // compares and protocol checks that went wrong.
   int cycles = 0;  // clock cycles since time zero.

   // expected readout words, one entry per baseline, in burst order.
   corr_pkg::baseline_t  exp_bl [$];
   corr_pkg::vis_count_t exp_re [$];
   corr_pkg::vis_count_t exp_im [$];

   // model state, shadowing the front end and the six accumulators.
   int                m_phase = 0;  // tick inside the sample period.
   int                m_cnt = 0;    // captures in the current block.
   int                m_blocks = 0; // blocks completed since reset.
   corr_pkg::sample_t m_prev = '0;  // last captured word, the next quadrature word.
   int                m_re [corr_pkg::BASELINE_COUNT];
   int                m_im [corr_pkg::BASELINE_COUNT];

   // the last burst seen on the outputs, indexed by baseline.
   corr_pkg::vis_count_t obs_re [corr_pkg::BASELINE_COUNT];
   corr_pkg::vis_count_t obs_im [corr_pkg::BASELINE_COUNT];
   logic                 prev_valid = 1'b0;
   corr_pkg::baseline_t  prev_bl = '0;

   tb_clock u_clock (
      .clk (clk),
      .rst (rst)
   );

   correlator_top DUT (
      .clk          (clk),
      .rst          (rst),
      .en           (en),
      .d            (d),
      .vis_valid    (vis_valid),
      .vis_baseline (vis_baseline),
      .vis_re       (vis_re),
      .vis_im       (vis_im)
   );

   // ==========================================================
   // compare tasks
   // ==========================================================

   task automatic compare_count(input string name, input corr_pkg::vis_count_t got,
                                input corr_pkg::vis_count_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
      end
   endtask

   task automatic compare_baseline(input string name, input corr_pkg::baseline_t got,
                                   input corr_pkg::baseline_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail at %0t ns: %s expected %b got %b", $time, name, exp, got);
      end
   endtask

   // ==========================================================
   // reference model and output monitor
   // ==========================================================

   // same edge as the DUT, so en and d are seen before the driver updates them.
   always @(posedge clk) begin : reference_model
      int a;
      int b;
      if (rst) begin
         m_phase = 0;
         m_cnt   = 0;
         m_prev  = '0;                          // no quadrature history after reset.
         for (int i = 0; i < corr_pkg::BASELINE_COUNT; i++) begin
            m_re[i] = 0;
            m_im[i] = 0;
         end
      end else begin
         if (en && m_phase == 0) begin          // a capture edge.
            for (int i = 0; i < corr_pkg::BASELINE_COUNT; i++) begin
               a = corr_pkg::BASE_ANT_A[i];
               b = corr_pkg::BASE_ANT_B[i];
               if (d[a] == d[b]) m_re[i]++;      // in-phase bits agree.
               if (d[a] == m_prev[b]) m_im[i]++; // a in-phase against b quadrature.
            end
            m_prev = d;
            m_cnt++;
            if (m_cnt == corr_pkg::BLOCK_LEN) begin
               for (int i = 0; i < corr_pkg::BASELINE_COUNT; i++) begin
                  exp_bl.push_back(corr_pkg::baseline_t'(i));
                  exp_re.push_back(corr_pkg::vis_count_t'(m_re[i]));
                  exp_im.push_back(corr_pkg::vis_count_t'(m_im[i]));
                  m_re[i] = 0;                  // each block starts from zero.
                  m_im[i] = 0;
               end
               m_cnt = 0;
               m_blocks++;
            end
         end
         if (en || m_phase != 0) begin          // a started period always completes.
            m_phase = (m_phase + 1) % corr_pkg::TICKS_PER_SAMPLE;
         end
      end
   end

   // outputs settle after the rising edge, so they are read on the falling one.
   always @(negedge clk) begin : output_monitor
      if (!rst) begin
         if (vis_valid) begin
            if (exp_re.size() == 0) begin
               errors++;
               $display("at %0t ns vis_valid was high with no block expected", $time);
            end else begin
               compare_baseline("vis_baseline", vis_baseline, exp_bl.pop_front());
               compare_count("vis_re", vis_re, exp_re.pop_front());
               compare_count("vis_im", vis_im, exp_im.pop_front());
               obs_re[int'(vis_baseline)] = vis_re;
               obs_im[int'(vis_baseline)] = vis_im;
            end
         end else if (prev_valid &&
                      prev_bl != corr_pkg::baseline_t'(corr_pkg::BASELINE_COUNT - 1)) begin
            errors++;
            $display("at %0t ns the readout burst stopped before the last baseline", $time);
         end
         prev_valid = vis_valid;
         prev_bl    = vis_baseline;
      end
   end

   always @(posedge clk) begin : run_limit
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, the tests did not finish", cycles);
         $display("Some tests failed");
         $finish;
      end
   end

   // ==========================================================
   // stimulus helpers
   // ==========================================================

   // holds one word for a whole sample period with en high.
   task automatic send_sample(input corr_pkg::sample_t word);
      @(posedge clk);
      en <= 1'b1;
      d  <= word;
      repeat (corr_pkg::TICKS_PER_SAMPLE - 1) @(posedge clk);
   endtask

   task automatic idle(input int n);
      @(posedge clk);
      en <= 1'b0;
      repeat (n - 1) @(posedge clk);
   endtask

   // returns once every queued result has appeared on the outputs.
   task automatic wait_drain();
      idle(1);
      while (exp_re.size() != 0) @(posedge clk);
      @(posedge clk);
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (errors == errors_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - errors_before);
      end
   endtask

   // ==========================================================
   // directed tests
   // ==========================================================

   task automatic test_reset_state();
      int e0;
      e0 = errors;
      do begin
         @(negedge clk);
         compare_flag("vis_valid", vis_valid, 1'b0);
      end while (rst);
      repeat (100) begin                        // en stays low, so nothing may come out.
         @(negedge clk);
         compare_flag("vis_valid", vis_valid, 1'b0);
      end
      report_test("reset state", e0);
   endtask

   task automatic test_constant_input();
      int e0;
      e0 = errors;
      repeat (corr_pkg::BLOCK_LEN) send_sample('1);
      wait_drain();
      // the first quadrature word is zero, so one imaginary agreement is lost.
      for (int i = 0; i < corr_pkg::BASELINE_COUNT; i++) begin
         compare_count("vis_re", obs_re[i], corr_pkg::vis_count_t'(16));
         compare_count("vis_im", obs_im[i], corr_pkg::vis_count_t'(15));
      end
      report_test("constant input", e0);
   endtask

   task automatic test_random_words();
      int e0;
      e0 = errors;
      repeat (2 * corr_pkg::BLOCK_LEN) send_sample(corr_pkg::sample_t'($urandom));
      wait_drain();
      report_test("random words", e0);
   endtask

   // en toggles every cycle at random until two more blocks have closed.
   task automatic test_enable_gaps();
      int e0;
      int target;
      e0     = errors;
      target = m_blocks + 2;
      while (m_blocks < target) begin
         @(posedge clk);
         en <= ($urandom % 4) != 0;
         d  <= corr_pkg::sample_t'($urandom);
         @(negedge clk);
      end
      wait_drain();
      report_test("enable gaps", e0);
   endtask

   task automatic test_alternating();
      int e0;
      e0 = errors;
      for (int s = 0; s < corr_pkg::BLOCK_LEN; s++) begin
         send_sample((s % 2 == 0) ? 4'b0101 : 4'b1010);
      end
      wait_drain();
      // antennas of equal parity always agree, the others never do.
      for (int i = 0; i < corr_pkg::BASELINE_COUNT; i++) begin
         compare_count("vis_re", obs_re[i],
            (corr_pkg::BASE_ANT_A[i] % 2 == corr_pkg::BASE_ANT_B[i] % 2) ?
            corr_pkg::vis_count_t'(16) : corr_pkg::vis_count_t'(0));
      end
      report_test("alternating antennas", e0);
   endtask

   initial begin
      en = 1'b0;
      d  = '0;
      void'($urandom(32'h69e9));                // one seed for the whole run.
      test_reset_state();
      test_constant_input();
      test_random_words();
      test_enable_gaps();
      test_alternating();
      $display("tests 5, checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
   output logic clk,
   output logic rst
);

   localparam int HALF_PERIOD = 4; // 8 ns clock period.
   localparam int RESET_LEN   = 3; // cycles of reset at the start.

   initial begin
      clk = 1'b0;                               // starts low so the first edge is a rise.
      forever #HALF_PERIOD clk = ~clk;
   end

   initial begin
      rst = 1'b1;                               // reset is active from time zero.
      repeat (RESET_LEN) @(posedge clk);
      rst <= 1'b0;                              // released on a rising edge like any input.
   end

endmodule
